//--- source/ext_periph_pkg.sv
// widths and types shared by the external peripheral subsystem
// address map, peripheral indices and register word offsets
package ext_periph_pkg;

  typedef logic [31:0] reg_addr_t;
  typedef logic [31:0] reg_data_t;

  // word offset inside a window, address bits 7:2
  typedef logic [5:0] reg_offset_t;

  localparam int unsigned NUM_PERIPHS = 2;

  // one bit per peripheral, indexed as below
  typedef logic [NUM_PERIPHS-1:0] periph_sel_t;
  typedef logic [NUM_PERIPHS-1:0] intr_vec_t;

  localparam int unsigned GPIO_CNT_IDX = 0;
  localparam int unsigned PWR_SW_IDX   = 1;

  // address map
  localparam reg_addr_t GPIO_CNT_BASE = 32'h0000_0000;
  localparam reg_addr_t PWR_SW_BASE   = 32'h0000_0100;
  localparam reg_addr_t PERIPH_WINDOW = 32'd256;

  // gpio counter registers
  localparam reg_offset_t GPIO_CNT_CTRL   = 6'd0;
  localparam reg_offset_t GPIO_CNT_MAX    = 6'd1;
  // read-only
  localparam reg_offset_t GPIO_CNT_VALUE  = 6'd2;
  // bit 0 pending, write 1 to clear
  localparam reg_offset_t GPIO_CNT_STATUS = 6'd3;

  // power switch registers
  localparam reg_offset_t PWR_SW_REQ    = 6'd0;
  // read-only, end of the ack delay line
  localparam reg_offset_t PWR_SW_ACK    = 6'd1;
  // bit 0 pending, write 1 to clear
  localparam reg_offset_t PWR_SW_STATUS = 6'd2;

endpackage

//--- source/reg_access_if.sv
// decoded register access from the decode stage
// to the peripherals and the result stage
interface reg_access_if ();
  import ext_periph_pkg::*;

  logic        valid;
  logic        we;
  periph_sel_t sel;
  reg_offset_t offset;
  reg_data_t   wdata;
  // set when the address hit no window
  logic        err;

  modport decoder (
    output valid, we, sel, offset, wdata, err
  );

  modport periph (
    input valid, we, sel, offset, wdata
  );

  modport result (
    input valid, sel, err
  );

endinterface

//--- source/reg_addr_decode.sv
// request decode stage
// matches the address against the map and registers the access
module reg_addr_decode (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      req_i,
  input  logic                      req_we_i,
  input  ext_periph_pkg::reg_addr_t req_addr_i,
  input  ext_periph_pkg::reg_data_t req_wdata_i,
  reg_access_if.decoder             acc_o
);
  import ext_periph_pkg::*;

  periph_sel_t sel_d;

  // true when addr falls inside the window starting at base
  function automatic logic in_window(reg_addr_t addr, reg_addr_t base);
    return (addr >= base) && (addr < base + PERIPH_WINDOW);
  endfunction

  always_comb begin
    sel_d = '0;
    sel_d[GPIO_CNT_IDX] = in_window(req_addr_i, GPIO_CNT_BASE);
    sel_d[PWR_SW_IDX]   = in_window(req_addr_i, PWR_SW_BASE);
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      acc_o.valid <= 1'b0;
    end else begin
      acc_o.valid <= req_i;
    end
  end

  // payload only loads on a request strobe
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      acc_o.we     <= req_we_i;
      acc_o.sel    <= sel_d;
      acc_o.offset <= req_addr_i[7:2];
      acc_o.wdata  <= req_wdata_i;
      acc_o.err    <= ~|sel_d;
    end
  end

endmodule

//--- source/gpio_cnt.sv
// gpio rising-edge counter peripheral
// ctrl, max, value and status registers with a pending interrupt
module gpio_cnt #(
  parameter ext_periph_pkg::reg_data_t CNT_MAX_RESET = 32'd2048
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  reg_access_if.periph              acc_i,
  input  logic                      gpio_i,
  output logic                      gpio_o,
  output ext_periph_pkg::reg_data_t rdata_o,
  output logic                      intr_o
);
  import ext_periph_pkg::*;

  logic      cnt_en_q;
  reg_data_t cnt_max_q;
  reg_data_t cnt_value_q;
  logic      pending_q;
  logic      gpio_q;
  logic      wr_en;
  logic      edge_cnt;
  logic      cnt_wrap;

  assign wr_en    = acc_i.valid & acc_i.we & acc_i.sel[GPIO_CNT_IDX];
  // counted edge, only while enabled
  assign edge_cnt = cnt_en_q & gpio_i & ~gpio_q;
  assign cnt_wrap = edge_cnt & ((cnt_value_q + 32'd1) >= cnt_max_q);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_en_q    <= 1'b0;
      cnt_max_q   <= CNT_MAX_RESET;
      cnt_value_q <= '0;
      pending_q   <= 1'b0;
      gpio_q      <= 1'b0;
      gpio_o      <= 1'b0;
    end else begin
      gpio_q <= gpio_i;
      // one-cycle pulse on the edge that wraps the count
      gpio_o <= cnt_wrap;

      if (cnt_wrap) begin
        cnt_value_q <= '0;
      end else if (edge_cnt) begin
        cnt_value_q <= cnt_value_q + 32'd1;
      end

      if (wr_en && (acc_i.offset == GPIO_CNT_CTRL)) begin
        cnt_en_q <= acc_i.wdata[0];
      end
      if (wr_en && (acc_i.offset == GPIO_CNT_MAX)) begin
        cnt_max_q <= acc_i.wdata;
      end

      // a new wrap wins over a clear in the same cycle
      if (cnt_wrap) begin
        pending_q <= 1'b1;
      end else if (wr_en && (acc_i.offset == GPIO_CNT_STATUS) && acc_i.wdata[0]) begin
        pending_q <= 1'b0;
      end
    end
  end

  // read data at the current offset
  always_comb begin
    rdata_o = '0;
    case (acc_i.offset)
      GPIO_CNT_CTRL:   rdata_o[0] = cnt_en_q;
      GPIO_CNT_MAX:    rdata_o = cnt_max_q;
      GPIO_CNT_VALUE:  rdata_o = cnt_value_q;
      GPIO_CNT_STATUS: rdata_o[0] = pending_q;
      default:         rdata_o = '0;
    endcase
  end

  assign intr_o = pending_q;

endmodule

//--- source/power_switch_emu.sv
// power switch emulator with per-domain active-low requests
// acknowledge delay line and interrupt on acknowledge change
module power_switch_emu #(
  parameter int unsigned NUM_DOMAINS        = 2,
  parameter int unsigned SWITCH_ACK_LATENCY = 15
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  reg_access_if.periph              acc_i,
  output logic [NUM_DOMAINS-1:0]    switch_n_o,
  output logic [NUM_DOMAINS-1:0]    ack_n_o,
  output ext_periph_pkg::reg_data_t rdata_o,
  output logic                      intr_o
);
  import ext_periph_pkg::*;

  localparam int unsigned LINE_W = SWITCH_ACK_LATENCY * NUM_DOMAINS;

  logic [NUM_DOMAINS-1:0]        switch_n_q;
  // delay line, stage 0 in the low bits
  logic [LINE_W-1:0]             ack_line_q;
  // request followed by every stage of the line
  logic [LINE_W+NUM_DOMAINS-1:0] ack_chain;
  // value the last stage takes on the next edge
  logic [NUM_DOMAINS-1:0]        ack_next;
  logic                          pending_q;
  logic                          wr_en;

  assign wr_en     = acc_i.valid & acc_i.we & acc_i.sel[PWR_SW_IDX];
  assign ack_chain = {ack_line_q, switch_n_q};
  assign ack_next  = ack_chain[LINE_W-1 -: NUM_DOMAINS];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      // all domains off
      switch_n_q <= '1;
      ack_line_q <= '1;
      pending_q  <= 1'b0;
    end else begin
      if (wr_en && (acc_i.offset == PWR_SW_REQ)) begin
        switch_n_q <= acc_i.wdata[NUM_DOMAINS-1:0];
      end

      // shift by one stage per cycle
      ack_line_q <= ack_chain[LINE_W-1:0];

      // flag the edge on which ack_n_o changes
      if (ack_next != ack_n_o) begin
        pending_q <= 1'b1;
      end else if (wr_en && (acc_i.offset == PWR_SW_STATUS) && acc_i.wdata[0]) begin
        pending_q <= 1'b0;
      end
    end
  end

  assign switch_n_o = switch_n_q;
  assign ack_n_o    = ack_line_q[LINE_W-1 -: NUM_DOMAINS];

  // read data at the current offset, zero above the domain bits
  always_comb begin
    rdata_o = '0;
    case (acc_i.offset)
      PWR_SW_REQ: begin
        rdata_o[NUM_DOMAINS-1:0] = switch_n_q;
      end
      PWR_SW_ACK: begin
        rdata_o[NUM_DOMAINS-1:0] = ack_n_o;
      end
      PWR_SW_STATUS: begin
        rdata_o[0] = pending_q;
      end
      default: begin
        rdata_o = '0;
      end
    endcase
  end

  assign intr_o = pending_q;

endmodule

//--- source/reg_rsp_mux.sv
// result stage
// picks the addressed peripheral's read data and registers the response
module reg_rsp_mux (
  input  logic                      clk_i,
  input  logic                      rst_i,
  reg_access_if.result              acc_i,
  input  ext_periph_pkg::reg_data_t gpio_rdata_i,
  input  ext_periph_pkg::reg_data_t pwr_rdata_i,
  output logic                      rsp_valid_o,
  output ext_periph_pkg::reg_data_t rsp_rdata_o,
  output logic                      rsp_error_o
);
  import ext_periph_pkg::*;

  reg_data_t rdata_sel;

  always_comb begin
    // no window hit, as on a decode error, returns zero data
    rdata_sel = '0;
    if (acc_i.sel[GPIO_CNT_IDX]) begin
      rdata_sel = gpio_rdata_i;
    end else if (acc_i.sel[PWR_SW_IDX]) begin
      rdata_sel = pwr_rdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_o <= 1'b0;
      rsp_error_o <= 1'b0;
    end else begin
      rsp_valid_o <= acc_i.valid;
      rsp_error_o <= acc_i.valid & acc_i.err;
    end
  end

  // data holds between responses
  always_ff @(posedge clk_i) begin
    if (acc_i.valid) begin
      rsp_rdata_o <= rdata_sel;
    end
  end

endmodule

//--- source/ext_periph_subsys.sv
// external peripheral subsystem top level
// decode stage, gpio counter, power switch emulator and result stage
module ext_periph_subsys #(
  parameter int unsigned               NUM_DOMAINS        = 2,
  parameter int unsigned               SWITCH_ACK_LATENCY = 15,
  parameter ext_periph_pkg::reg_data_t CNT_MAX_RESET      = 32'd2048
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  // register bus request
  input  logic                      req_i,
  input  logic                      req_we_i,
  input  ext_periph_pkg::reg_addr_t req_addr_i,
  input  ext_periph_pkg::reg_data_t req_wdata_i,
  // register bus response
  output logic                      rsp_valid_o,
  output ext_periph_pkg::reg_data_t rsp_rdata_o,
  output logic                      rsp_error_o,
  input  logic                      gpio_i,
  output logic                      gpio_o,
  output logic [NUM_DOMAINS-1:0]    pwr_switch_n_o,
  output logic [NUM_DOMAINS-1:0]    pwr_ack_n_o,
  output ext_periph_pkg::intr_vec_t intr_o
);
  import ext_periph_pkg::*;

  reg_data_t gpio_rdata;
  reg_data_t pwr_rdata;
  logic      gpio_intr;
  logic      pwr_intr;

  reg_access_if acc_if ();

  reg_addr_decode reg_addr_decode_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (req_i),
    .req_we_i    (req_we_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .acc_o       (acc_if.decoder)
  );

  gpio_cnt #(
    .CNT_MAX_RESET (CNT_MAX_RESET)
  ) gpio_cnt_inst (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .acc_i   (acc_if.periph),
    .gpio_i  (gpio_i),
    .gpio_o  (gpio_o),
    .rdata_o (gpio_rdata),
    .intr_o  (gpio_intr)
  );

  power_switch_emu #(
    .NUM_DOMAINS        (NUM_DOMAINS),
    .SWITCH_ACK_LATENCY (SWITCH_ACK_LATENCY)
  ) power_switch_emu_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .acc_i      (acc_if.periph),
    .switch_n_o (pwr_switch_n_o),
    .ack_n_o    (pwr_ack_n_o),
    .rdata_o    (pwr_rdata),
    .intr_o     (pwr_intr)
  );

  reg_rsp_mux reg_rsp_mux_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .acc_i        (acc_if.result),
    .gpio_rdata_i (gpio_rdata),
    .pwr_rdata_i  (pwr_rdata),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_rdata_o  (rsp_rdata_o),
    .rsp_error_o  (rsp_error_o)
  );

  // interrupt lines at their peripheral index
  always_comb begin
    intr_o = '0;
    intr_o[GPIO_CNT_IDX] = gpio_intr;
    intr_o[PWR_SW_IDX]   = pwr_intr;
  end

endmodule

//--- test/tb_ext_periph_tasks.svh
// register bus access, gpio stimulus and acknowledge wait tasks
// compare tasks for data, error flag, single bits, interrupts and domains
`ifndef TB_EXT_PERIPH_TASKS_SVH
`define TB_EXT_PERIPH_TASKS_SVH

task automatic fail_stop(input string why);
  $display("%s", why);
  $display("CHECKS FAILED");
  $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_data(input reg_data_t got, input reg_data_t exp, input string what);
  if (got !== exp) begin
    fail_stop($sformatf("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp));
  end
endtask

task automatic check_error(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    fail_stop($sformatf("Mismatch at %0t ns: %s error is %b, expected %b",
                        $time, what, got, exp));
  end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    fail_stop($sformatf("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp));
  end
endtask

task automatic check_intr(input intr_vec_t got, input intr_vec_t exp, input string what);
  if (got !== exp) begin
    fail_stop($sformatf("Mismatch at %0t ns: %s intr_o is %b, expected %b",
                        $time, what, got, exp));
  end
endtask

task automatic check_domains(input domain_vec_t got, input domain_vec_t exp,
                             input string what);
  if (got !== exp) begin
    fail_stop($sformatf("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp));
  end
endtask

function automatic reg_addr_t reg_addr(input reg_addr_t base, input reg_offset_t off);
  return base + reg_addr_t'({off, 2'b00});
endfunction

function automatic intr_vec_t intr_bit(input int unsigned idx);
  return intr_vec_t'(1) << idx;
endfunction

// one strobe, then wait for the response and its drop
task automatic bus_access(input logic we, input reg_addr_t addr, input reg_data_t wdata,
                          output reg_data_t rdata, output logic err);
  int unsigned waited;
  req_i       = 1'b1;
  req_we_i    = we;
  req_addr_i  = addr;
  req_wdata_i = wdata;
  @(posedge clk_i);
  #DRIVE_DELAY;
  req_i    = 1'b0;
  req_we_i = 1'b0;
  waited   = 0;
  while (!rsp_valid_o) begin
    if (waited >= RSP_TIMEOUT) begin
      fail_stop("timeout: no response to a register access");
    end
    @(posedge clk_i);
    #DRIVE_DELAY;
    waited++;
  end
  rdata = rsp_rdata_o;
  err   = rsp_error_o;
  @(posedge clk_i);
  #DRIVE_DELAY;
  check_flag(rsp_valid_o, 1'b0, "rsp_valid_o one cycle after the response");
endtask

task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
  reg_data_t rdata;
  logic      err;
  bus_access(1'b1, addr, data, rdata, err);
  check_error(err, 1'b0, "register write");
endtask

task automatic read_expect(input reg_addr_t addr, input reg_data_t exp, input string what);
  reg_data_t rdata;
  logic      err;
  bus_access(1'b0, addr, '0, rdata, err);
  check_error(err, 1'b0, what);
  check_data(rdata, exp, what);
endtask

task automatic drive_gpio_pulses(input int unsigned n);
  repeat (n) begin
    gpio_i = 1'b1;
    @(posedge clk_i);
    #DRIVE_DELAY;
    gpio_i = 1'b0;
    @(posedge clk_i);
    #DRIVE_DELAY;
  end
endtask

task automatic wait_ack(input domain_vec_t exp);
  int unsigned waited;
  waited = 0;
  while (pwr_ack_n_o !== exp) begin
    if (waited >= ACK_TIMEOUT) begin
      fail_stop("timeout: pwr_ack_n_o never reached the requested value");
    end
    @(posedge clk_i);
    #DRIVE_DELAY;
    waited++;
  end
endtask

`endif

//--- test/tb_ext_periph_subsys.sv
// testbench top for the external peripheral subsystem
// clock, reset, DUT instance and the directed tests
module tb_ext_periph_subsys;
  timeunit 1ns;
  timeprecision 1ns;
  import ext_periph_pkg::*;

  localparam int unsigned NUM_DOMAINS        = 2;
  localparam int unsigned SWITCH_ACK_LATENCY = 15;
  localparam reg_data_t   CNT_MAX_RESET      = 32'd2048;
  localparam int unsigned CLK_PERIOD         = 100;
  localparam int unsigned DRIVE_DELAY        = 10;
  localparam int unsigned RESET_CYCLES       = 4;
  localparam int unsigned RSP_TIMEOUT        = 8;
  localparam int unsigned ACK_TIMEOUT        = 20;
  localparam int unsigned SEED               = 32'ha67;
  localparam reg_data_t   DOMAIN_MASK        = 32'hffff_ffff >> (32 - NUM_DOMAINS);
  // first address past both windows
  localparam reg_addr_t   UNMAPPED_ADDR      = 32'h0000_0200;

  typedef logic [NUM_DOMAINS-1:0] domain_vec_t;

  logic        clk_i;
  logic        rst_i;
  logic        req_i;
  logic        req_we_i;
  reg_addr_t   req_addr_i;
  reg_data_t   req_wdata_i;
  logic        rsp_valid_o;
  reg_data_t   rsp_rdata_o;
  logic        rsp_error_o;
  logic        gpio_i;
  logic        gpio_o;
  domain_vec_t pwr_switch_n_o;
  domain_vec_t pwr_ack_n_o;
  intr_vec_t   intr_o;

  int unsigned gpio_pulses_seen;
  reg_data_t   exp_gpio_max;
  domain_vec_t exp_pwr_req;
  // pipelined burst, one entry per request
  logic        burst_we[$];
  reg_addr_t   burst_addr[$];
  reg_data_t   burst_wdata[$];
  reg_data_t   burst_exp[$];

  `include "tb_ext_periph_tasks.svh"

  ext_periph_subsys #(
    .NUM_DOMAINS        (NUM_DOMAINS),
    .SWITCH_ACK_LATENCY (SWITCH_ACK_LATENCY),
    .CNT_MAX_RESET      (CNT_MAX_RESET)
  ) ext_periph_subsys_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_i          (req_i),
    .req_we_i       (req_we_i),
    .req_addr_i     (req_addr_i),
    .req_wdata_i    (req_wdata_i),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_rdata_o    (rsp_rdata_o),
    .rsp_error_o    (rsp_error_o),
    .gpio_i         (gpio_i),
    .gpio_o         (gpio_o),
    .pwr_switch_n_o (pwr_switch_n_o),
    .pwr_ack_n_o    (pwr_ack_n_o),
    .intr_o         (intr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // count gpio_o pulses mid-cycle
  always @(negedge clk_i) begin
    if (rst_i) begin
      gpio_pulses_seen <= 0;
    end else if (gpio_o) begin
      gpio_pulses_seen <= gpio_pulses_seen + 1;
    end
  end

  task automatic add_burst(input logic we, input reg_addr_t addr, input reg_data_t wdata,
                           input reg_data_t exp);
    burst_we.push_back(we);
    burst_addr.push_back(addr);
    burst_wdata.push_back(wdata);
    burst_exp.push_back(exp);
  endtask

  // one strobe per cycle, response k seen two cycles after strobe k
  task automatic run_burst();
    int unsigned n;
    n = burst_we.size();
    for (int unsigned c = 0; c < n + 3; c++) begin
      req_i = logic'(c < n);
      if (c < n) begin
        req_we_i    = burst_we[c];
        req_addr_i  = burst_addr[c];
        req_wdata_i = burst_wdata[c];
      end
      check_flag(rsp_valid_o, logic'((c >= 2) && (c < n + 2)), "rsp_valid_o in burst");
      if ((c >= 2) && (c < n + 2)) begin
        check_error(rsp_error_o, 1'b0, "burst response");
        check_data(rsp_rdata_o, burst_exp[c - 2], "burst response data");
      end
      @(posedge clk_i);
      #DRIVE_DELAY;
    end
    req_we_i = 1'b0;
  endtask

  task automatic test_reset_values();
    check_flag(rsp_valid_o, 1'b0, "rsp_valid_o after reset");
    check_error(rsp_error_o, 1'b0, "rsp_error_o after reset");
    check_flag(gpio_o, 1'b0, "gpio_o after reset");
    check_intr(intr_o, '0, "after reset");
    check_domains(pwr_switch_n_o, '1, "pwr_switch_n_o after reset");
    check_domains(pwr_ack_n_o, '1, "pwr_ack_n_o after reset");
    read_expect(reg_addr(GPIO_CNT_BASE, GPIO_CNT_MAX), CNT_MAX_RESET, "GPIO_CNT_MAX reset");
    read_expect(reg_addr(PWR_SW_BASE, PWR_SW_REQ), DOMAIN_MASK, "PWR_SW_REQ reset");
    read_expect(reg_addr(PWR_SW_BASE, PWR_SW_ACK), DOMAIN_MASK, "PWR_SW_ACK reset");
    exp_gpio_max = CNT_MAX_RESET;
    exp_pwr_req  = '1;
  endtask

  task automatic test_back_to_back();
    reg_data_t max_val;
    reg_data_t req_val;
    max_val = $urandom();
    req_val = $urandom();
    burst_we.delete();
    burst_addr.delete();
    burst_wdata.delete();
    burst_exp.delete();
    // writes answer with the old value
    add_burst(1'b1, reg_addr(GPIO_CNT_BASE, GPIO_CNT_MAX), max_val, exp_gpio_max);
    add_burst(1'b1, reg_addr(PWR_SW_BASE, PWR_SW_REQ), req_val, reg_data_t'(exp_pwr_req));
    add_burst(1'b0, reg_addr(GPIO_CNT_BASE, GPIO_CNT_MAX), '0, max_val);
    add_burst(1'b0, reg_addr(PWR_SW_BASE, PWR_SW_REQ), '0, req_val & DOMAIN_MASK);
    run_burst();
    exp_gpio_max = max_val;
    exp_pwr_req  = req_val[NUM_DOMAINS-1:0];
    // let the request reach the ack, then switch all domains off again
    wait_ack(exp_pwr_req);
    write_reg(reg_addr(PWR_SW_BASE, PWR_SW_REQ), DOMAIN_MASK);
    exp_pwr_req = '1;
    wait_ack(exp_pwr_req);
    write_reg(reg_addr(PWR_SW_BASE, PWR_SW_STATUS), 32'd1);
    check_intr(intr_o, '0, "after power switch settle");
  endtask

  task automatic test_decode_error();
    reg_data_t rdata;
    logic      err;
    bus_access(1'b0, UNMAPPED_ADDR, '0, rdata, err);
    check_error(err, 1'b1, "unmapped read");
    check_data(rdata, '0, "unmapped read data");
    // enable bit set and domain bits away from the all-off request
    bus_access(1'b1, UNMAPPED_ADDR, ($urandom() & ~DOMAIN_MASK) | 32'd1, rdata, err);
    check_error(err, 1'b1, "unmapped write at offset 0");
    check_data(rdata, '0, "unmapped write data");
    bus_access(1'b1, UNMAPPED_ADDR + 32'd4, $urandom(), rdata, err);
    check_error(err, 1'b1, "unmapped write at offset 1");
    check_data(rdata, '0, "unmapped write data");
    read_expect(reg_addr(GPIO_CNT_BASE, GPIO_CNT_CTRL), '0, "GPIO_CNT_CTRL kept");
    read_expect(reg_addr(GPIO_CNT_BASE, GPIO_CNT_MAX), exp_gpio_max, "GPIO_CNT_MAX kept");
    read_expect(reg_addr(PWR_SW_BASE, PWR_SW_REQ), reg_data_t'(exp_pwr_req), "PWR_SW_REQ kept");
  endtask

  task automatic test_gpio_counter();
    int unsigned pulses_before;
    write_reg(reg_addr(GPIO_CNT_BASE, GPIO_CNT_MAX), 32'd5);
    exp_gpio_max = 32'd5;
    write_reg(reg_addr(GPIO_CNT_BASE, GPIO_CNT_CTRL), 32'd1);
    read_expect(reg_addr(GPIO_CNT_BASE, GPIO_CNT_VALUE), '0, "GPIO_CNT_VALUE start");
    pulses_before = gpio_pulses_seen;
    drive_gpio_pulses(4);
    read_expect(reg_addr(GPIO_CNT_BASE, GPIO_CNT_VALUE), 32'd4, "GPIO_CNT_VALUE after 4");
    check_data(reg_data_t'(gpio_pulses_seen - pulses_before), '0, "gpio_o pulses before wrap");
    check_intr(intr_o, '0, "before counter wrap");
    drive_gpio_pulses(1);
    read_expect(reg_addr(GPIO_CNT_BASE, GPIO_CNT_VALUE), '0, "GPIO_CNT_VALUE after wrap");
    check_data(reg_data_t'(gpio_pulses_seen - pulses_before), 32'd1, "gpio_o pulses at wrap");
    check_intr(intr_o, intr_bit(GPIO_CNT_IDX), "after counter wrap");
    read_expect(reg_addr(GPIO_CNT_BASE, GPIO_CNT_STATUS), 32'd1, "GPIO_CNT_STATUS pending");
    write_reg(reg_addr(GPIO_CNT_BASE, GPIO_CNT_STATUS), 32'd1);
    check_intr(intr_o, '0, "after GPIO_CNT_STATUS clear");
    drive_gpio_pulses(2);
    read_expect(reg_addr(GPIO_CNT_BASE, GPIO_CNT_VALUE), 32'd2, "GPIO_CNT_VALUE after 2");
    // disabled counter ignores edges
    write_reg(reg_addr(GPIO_CNT_BASE, GPIO_CNT_CTRL), '0);
    drive_gpio_pulses(3);
    read_expect(reg_addr(GPIO_CNT_BASE, GPIO_CNT_VALUE), 32'd2, "GPIO_CNT_VALUE disabled");
    check_data(reg_data_t'(gpio_pulses_seen - pulses_before), 32'd1, "gpio_o pulses disabled");
    check_intr(intr_o, '0, "counter disabled");
  endtask

  task automatic test_power_switch();
    reg_data_t req_val;
    check_intr(intr_o, '0, "before power switch request");
    req_val = $urandom() & DOMAIN_MASK;
    // make sure at least one domain turns on
    if (req_val == DOMAIN_MASK) begin
      req_val = req_val ^ 32'd1;
    end
    write_reg(reg_addr(PWR_SW_BASE, PWR_SW_REQ), req_val);
    exp_pwr_req = req_val[NUM_DOMAINS-1:0];
    check_domains(pwr_switch_n_o, exp_pwr_req, "pwr_switch_n_o after write");
    check_domains(pwr_ack_n_o, '1, "pwr_ack_n_o before the latency");
    wait_ack(exp_pwr_req);
    check_intr(intr_o, intr_bit(PWR_SW_IDX), "after ack change");
    read_expect(reg_addr(PWR_SW_BASE, PWR_SW_ACK), req_val, "PWR_SW_ACK");
    read_expect(reg_addr(PWR_SW_BASE, PWR_SW_STATUS), 32'd1, "PWR_SW_STATUS pending");
    write_reg(reg_addr(PWR_SW_BASE, PWR_SW_STATUS), 32'd1);
    check_intr(intr_o, '0, "after PWR_SW_STATUS clear");
    read_expect(reg_addr(PWR_SW_BASE, PWR_SW_STATUS), '0, "PWR_SW_STATUS cleared");
  endtask

  initial begin
    void'($urandom(SEED));
    rst_i       = 1'b1;
    req_i       = 1'b0;
    req_we_i    = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    gpio_i      = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_i = 1'b0;
    test_reset_values();
    test_back_to_back();
    test_decode_error();
    test_gpio_counter();
    test_power_switch();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- src.f
+incdir+test
source/ext_periph_pkg.sv
source/reg_access_if.sv
source/reg_addr_decode.sv
source/gpio_cnt.sv
source/power_switch_emu.sv
source/reg_rsp_mux.sv
source/ext_periph_subsys.sv
test/tb_ext_periph_subsys.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ext_periph_subsys
BUILD_DIR ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --timescale 1ns/1ns

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard test/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the exit status of the simulator is the result of the run
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
